// File: Bender.yml
package:
  name: lcd_panel

dependencies: {}

# config header lives next to the rtl
export_include_dirs:
  - logic

sources:
  # package first, then rtl bottom up
  - include_dirs:
      - logic
    files:
      - logic/lcd_pkg.sv
      - logic/lcd_text_buf.sv
      - logic/lcd_sequencer.sv
      - logic/lcd_bus_timing.sv
      - logic/lcd_panel_top.sv

  # testbench
  - target: test
    include_dirs:
      - logic
    files:
      - tests/lcd_panel_tb.sv

// File: logic/lcd_bus_timing.sv
/*
  lcd bus timing
  turns one issued byte into the HD44780 write cycle:
  data and rs setup, a fixed e pulse, then an e-low gap,
  long after clear or home; done pulses in the last gap cycle
*/
`timescale 1ns/1ps
`include "lcd_cfg.svh"

module lcd_bus_timing (
  input  logic               lcd_clk,
  input  logic               rst_n,
  // byte from the sequencer
  input  logic               byte_issue,
  input  lcd_pkg::lcd_word_u byte_word,
  input  logic               byte_rs,
  output logic               byte_done,
  // panel pins
  output logic [7:0]         lcd_data,
  output logic               lcd_rs,
  output logic               lcd_e
);

  localparam logic [1:0] PH_IDLE   = 2'd0;
  localparam logic [1:0] PH_SETUP  = 2'd1;
  localparam logic [1:0] PH_E_HIGH = 2'd2;
  localparam logic [1:0] PH_GAP    = 2'd3;

  logic [1:0]  phase;
  // cycles left in the current phase, minus one
  logic [15:0] cnt;
  logic        long_gap;
  logic        clr_home;

  // clear is 0x01, return home is 0x02 or 0x03
  assign clr_home = !byte_rs && (byte_word.raw >= 8'h01) && (byte_word.raw <= 8'h03);

  // --------------------
  // phase walk
  // --------------------
  always_ff @(posedge lcd_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      phase    <= PH_IDLE;
      cnt      <= 16'd0;
      long_gap <= 1'b0;
      lcd_data <= 8'h00;
      lcd_rs   <= 1'b0;
    end
    else
    begin
      case (phase)
        PH_IDLE:
        begin
          if (byte_issue)
          begin
            // pins take the byte now and hold it until the next issue
            lcd_data <= byte_word.raw;
            lcd_rs   <= byte_rs;
            long_gap <= clr_home;
            phase    <= PH_SETUP;
            cnt      <= 16'(`LCD_SETUP_CYCLES - 1);
          end
        end
        PH_SETUP:
        begin
          if (cnt == 16'd0)
          begin
            phase <= PH_E_HIGH;
            cnt   <= 16'(`LCD_E_HIGH_CYCLES - 1);
          end
          else
            cnt <= cnt - 16'd1;
        end
        PH_E_HIGH:
        begin
          if (cnt == 16'd0)
          begin
            phase <= PH_GAP;
            cnt   <= long_gap ? 16'(`LCD_CLEAR_CYCLES - 1) : 16'(`LCD_GAP_CYCLES - 1);
          end
          else
            cnt <= cnt - 16'd1;
        end
        default:
        begin
          if (cnt == 16'd0)
            phase <= PH_IDLE;
          else
            cnt <= cnt - 16'd1;
        end
      endcase
    end
  end

  assign lcd_e     = (phase == PH_E_HIGH);
  assign byte_done = (phase == PH_GAP) && (cnt == 16'd0);

  // sequencer waits for done before the next byte
  a_issue_idle: assert property (
    @(posedge lcd_clk) disable iff (!rst_n)
    byte_issue |-> (phase == PH_IDLE)
  ) else $error("byte issued while a bus cycle is in progress");

  // panel latches on the falling e edge, bus must be quiet under e
  a_bus_stable: assert property (
    @(posedge lcd_clk) disable iff (!rst_n)
    lcd_e |-> ($stable(lcd_data) && $stable(lcd_rs))
  ) else $error("lcd data or rs moved while e was high");

endmodule

// File: logic/lcd_cfg.svh
/*
  lcd panel configuration
  cycle counts for the HD44780 bus cycle and power-up wait,
  row geometry and the setup instruction bytes
*/
`ifndef LCD_CFG_SVH
`define LCD_CFG_SVH

// --------------------
// bus timing in lcd_clk cycles
// --------------------
// data and rs held before e rises
`define LCD_SETUP_CYCLES 2
// e pulse width
`define LCD_E_HIGH_CYCLES 12
// e low after a normal byte
`define LCD_GAP_CYCLES 20
// e low after clear or home, cut down for simulation
`define LCD_CLEAR_CYCLES 200
// wait after reset before the first instruction
`define LCD_POWERUP_CYCLES 100

// --------------------
// panel geometry
// --------------------
`define LCD_COLS 16
// ddram address of the second row
`define LCD_ROW2_BASE 7'h40

// --------------------
// setup instructions, sent in this order
// --------------------
// 8-bit bus, two lines, 5x8 font
`define LCD_INIT_0 8'h38
// display off
`define LCD_INIT_1 8'h08
// clear display
`define LCD_INIT_2 8'h01
// increment, no shift
`define LCD_INIT_3 8'h06
// display on, cursor off
`define LCD_INIT_4 8'h0C

`endif

// File: logic/lcd_panel_top.sv
/*
  lcd panel controller top
  joins the text buffer, refresh sequencer and bus timing
  for a 2x16 HD44780 panel on an 8-bit write-only bus
*/
`timescale 1ns/1ps

module lcd_panel_top (
  input  logic              lcd_clk,
  input  logic              rst_n,
  // host text writes
  input  logic              wr_en,
  input  lcd_pkg::lcd_pos_t wr_pos,
  input  logic [7:0]        wr_char,
  // panel pins
  output logic [7:0]        lcd_data,
  output logic              lcd_rs,
  output logic              lcd_e,
  output logic              lcd_rw
);

  // buffer read path
  lcd_pkg::lcd_pos_t  rd_pos;
  logic [7:0]         rd_char;
  // byte handoff
  logic               byte_issue;
  lcd_pkg::lcd_word_u byte_word;
  logic               byte_rs;
  logic               byte_done;

  lcd_text_buf i_text_buf (
    .lcd_clk (lcd_clk),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .wr_pos  (wr_pos),
    .wr_char (wr_char),
    .rd_pos  (rd_pos),
    .rd_char (rd_char)
  );

  lcd_sequencer i_sequencer (
    .lcd_clk    (lcd_clk),
    .rst_n      (rst_n),
    .rd_pos     (rd_pos),
    .rd_char    (rd_char),
    .byte_issue (byte_issue),
    .byte_word  (byte_word),
    .byte_rs    (byte_rs),
    .byte_done  (byte_done)
  );

  lcd_bus_timing i_bus_timing (
    .lcd_clk    (lcd_clk),
    .rst_n      (rst_n),
    .byte_issue (byte_issue),
    .byte_word  (byte_word),
    .byte_rs    (byte_rs),
    .byte_done  (byte_done),
    .lcd_data   (lcd_data),
    .lcd_rs     (lcd_rs),
    .lcd_e      (lcd_e)
  );

  // no busy-flag reads, bus only ever writes
  assign lcd_rw = 1'b0;

endmodule

// File: logic/lcd_pkg.sv
/*
  lcd panel types
  bus word with raw and set-ddram-address views,
  and the text buffer position index
*/
package lcd_pkg;

  // one byte on the lcd data bus
  typedef union packed {
    // character code or full instruction byte
    logic [7:0] raw;
    // set-ddram-address instruction
    struct packed {
      // must be 1 for set-ddram
      logic       set_ddram;
      // ddram address, row 2 starts at 0x40
      logic [6:0] addr;
    } ddram;
  } lcd_word_u;

  // text buffer index
  // 0..15 row 1, 16..31 row 2
  // top bit selects the row
  typedef logic [4:0] lcd_pos_t;

endpackage

// File: logic/lcd_sequencer.sv
/*
  lcd refresh sequencer
  waits out power-up, sends the five setup instructions,
  then walks both rows forever, each row led by a set-ddram
  address; hands one byte at a time to the bus timing block
*/
`timescale 1ns/1ps
`include "lcd_cfg.svh"

module lcd_sequencer (
  input  logic               lcd_clk,
  input  logic               rst_n,
  // text buffer read
  output lcd_pkg::lcd_pos_t  rd_pos,
  input  logic [7:0]         rd_char,
  // byte handoff to bus timing
  output logic               byte_issue,
  output lcd_pkg::lcd_word_u byte_word,
  output logic               byte_rs,
  input  logic               byte_done
);

  // fsm states
  localparam logic [1:0] ST_POWERUP = 2'd0;
  localparam logic [1:0] ST_FETCH   = 2'd1;
  localparam logic [1:0] ST_ISSUE   = 2'd2;
  localparam logic [1:0] ST_WAIT    = 2'd3;

  // steps 0..4 are the setup bytes
  localparam logic [2:0] STEP_INIT_LAST = 3'd4;
  localparam logic [2:0] STEP_ROW       = 3'd5;
  localparam logic [2:0] STEP_CHAR      = 3'd6;

  logic [1:0]  state;
  logic [2:0]  step;
  // row being refreshed, 0 for row 1
  logic        row;
  logic [3:0]  col;
  logic [15:0] pwr_cnt;
  // row named by the last set-ddram address handed off
  logic        row_sent;

  // --------------------
  // control
  // --------------------
  always_ff @(posedge lcd_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= ST_POWERUP;
      step    <= 3'd0;
      row     <= 1'b0;
      col     <= 4'd0;
      pwr_cnt <= 16'(`LCD_POWERUP_CYCLES - 1);
    end
    else
    begin
      case (state)
        ST_POWERUP:
        begin
          // setup byte 0 needs no buffer read, go straight to issue
          if (pwr_cnt == 16'd0)
            state <= ST_ISSUE;
          else
            pwr_cnt <= pwr_cnt - 16'd1;
        end
        // rd_pos presented this cycle
        ST_FETCH: state <= ST_ISSUE;
        // rd_char valid, byte handed off
        ST_ISSUE: state <= ST_WAIT;
        ST_WAIT:
        begin
          if (byte_done)
          begin
            state <= ST_FETCH;
            case (step)
              STEP_INIT_LAST:
              begin
                // setup done, start the first frame on row 1
                step <= STEP_ROW;
                row  <= 1'b0;
                col  <= 4'd0;
              end
              STEP_ROW: step <= STEP_CHAR;
              STEP_CHAR:
              begin
                if (col == 4'(`LCD_COLS - 1))
                begin
                  // end of row, flip to the other row start
                  col  <= 4'd0;
                  row  <= ~row;
                  step <= STEP_ROW;
                end
                else
                begin
                  col <= col + 4'd1;
                end
              end
              // next setup byte
              default: step <= step + 3'd1;
            endcase
          end
        end
        default: state <= ST_POWERUP;
      endcase
    end
  end

  // --------------------
  // outputs
  // --------------------
  assign rd_pos     = {row, col};
  assign byte_issue = (state == ST_ISSUE);
  // characters only, instructions go with rs low
  assign byte_rs    = (step == STEP_CHAR);

  always_comb
  begin
    byte_word = '0;
    case (step)
      3'd0: byte_word.raw = `LCD_INIT_0;
      3'd1: byte_word.raw = `LCD_INIT_1;
      3'd2: byte_word.raw = `LCD_INIT_2;
      3'd3: byte_word.raw = `LCD_INIT_3;
      3'd4: byte_word.raw = `LCD_INIT_4;
      STEP_ROW:
      begin
        // set-ddram to the start of the current row
        byte_word.ddram.set_ddram = 1'b1;
        byte_word.ddram.addr      = row ? `LCD_ROW2_BASE : 7'h00;
      end
      default: byte_word.raw = rd_char;
    endcase
  end

  // decode the row-start words as they leave
  always_ff @(posedge lcd_clk or negedge rst_n)
  begin
    if (!rst_n)
      row_sent <= 1'b0;
    else if (byte_issue && !byte_rs && byte_word.ddram.set_ddram)
      row_sent <= (byte_word.ddram.addr == `LCD_ROW2_BASE);
  end

  // characters must be read from the row whose start address went out last
  a_row_held: assert property (
    @(posedge lcd_clk) disable iff (!rst_n)
    (byte_issue && byte_rs) |-> (rd_pos[4] == row_sent)
  ) else $error("read position left the current row during character send");

endmodule

// File: logic/lcd_text_buf.sv
/*
  lcd text buffer
  32 character registers, one per panel position,
  written by host strobes and read by the refresh sequencer
  through a registered port
*/
`timescale 1ns/1ps
`include "lcd_cfg.svh"

module lcd_text_buf (
  input  logic              lcd_clk,
  input  logic              rst_n,
  // host write port
  input  logic              wr_en,
  input  lcd_pkg::lcd_pos_t wr_pos,
  input  logic [7:0]        wr_char,
  // sequencer read port
  input  lcd_pkg::lcd_pos_t rd_pos,
  output logic [7:0]        rd_char
);

  // two rows of characters
  logic [7:0] mem [2*`LCD_COLS];

  // --------------------
  // write side
  // --------------------
  // blank panel after reset
  // ascii space in every entry
  always_ff @(posedge lcd_clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 2*`LCD_COLS; i++)
      begin
        mem[i] <= 8'h20;
      end
    end
    else if (wr_en)
    begin
      mem[wr_pos] <= wr_char;
    end
  end

  // --------------------
  // read side
  // --------------------
  // one cycle latency
  // same-cycle write to rd_pos shows up on the next read
  always_ff @(posedge lcd_clk)
  begin
    rd_char <= mem[rd_pos];
  end

  // host must give a real position with every strobe
  a_wr_pos_known: assert property (
    @(posedge lcd_clk) disable iff (!rst_n)
    wr_en |-> !$isunknown(wr_pos)
  ) else $error("host write with unknown position");

endmodule

// File: tb.f
+incdir+logic
logic/lcd_pkg.sv
logic/lcd_text_buf.sv
logic/lcd_sequencer.sv
logic/lcd_bus_timing.sv
logic/lcd_panel_top.sv
tests/lcd_panel_tb.sv

// File: tests/lcd_panel_tb.sv
/*
  lcd panel controller testbench
  seeded random host writes, a pin-level bus monitor,
  a shadow-buffer model of the byte stream, bus timing checks
  and a cycle-count watchdog
*/
`timescale 1ns/1ps
`include "lcd_cfg.svh"

module lcd_panel_tb;

  // one row-start and a row of characters per row
  localparam int FRAME_BYTES = 2 * (`LCD_COLS + 1);
  // five setup bytes, then four frames
  localparam int TOTAL_BYTES = 5 + 4 * FRAME_BYTES;
  localparam int BYTE_CYCLES = `LCD_SETUP_CYCLES + `LCD_E_HIGH_CYCLES + `LCD_GAP_CYCLES + 4;
  localparam int TIMEOUT_CYCLES =
    2 * (`LCD_POWERUP_CYCLES + 4 * (`LCD_CLEAR_CYCLES + 40) + 5 * FRAME_BYTES * BYTE_CYCLES);

  logic              lcd_clk;
  logic              rst_n;
  logic              wr_en;
  lcd_pkg::lcd_pos_t wr_pos;
  logic [7:0]        wr_char;
  logic [7:0]        lcd_data;
  logic              lcd_rs;
  logic              lcd_e;
  logic              lcd_rw;

  // model state
  logic [7:0] shadow [2*`LCD_COLS];
  logic       cur_row;
  logic       row_known;

  // monitor state
  lcd_pkg::lcd_word_u word;
  logic [8:0] bus;
  logic [8:0] last_bus;
  logic       bus_changed;
  logic       prev_e;
  logic       seen_rise;
  logic       long_gap;
  int         stable_cnt;
  int         e_hi_cnt;
  int         e_lo_cnt;
  int         byte_cnt;

  int errors;
  int checks;
  int writes;
  int cycle_cnt;

  lcd_panel_top i_dut (
    .lcd_clk  (lcd_clk),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_pos   (wr_pos),
    .wr_char  (wr_char),
    .lcd_data (lcd_data),
    .lcd_rs   (lcd_rs),
    .lcd_e    (lcd_e),
    .lcd_rw   (lcd_rw)
  );

  // 8 ns clock
  initial
  begin
    lcd_clk = 1'b0;
    forever #4 lcd_clk = ~lcd_clk;
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  // --------------------
  // reference model
  // --------------------
  // expected {rs, data} of the idx-th byte on the pins
  function automatic logic [8:0] predict_byte(input int idx);
    int k;
    case (idx)
      0: return {1'b0, `LCD_INIT_0};
      1: return {1'b0, `LCD_INIT_1};
      2: return {1'b0, `LCD_INIT_2};
      3: return {1'b0, `LCD_INIT_3};
      4: return {1'b0, `LCD_INIT_4};
      default: k = (idx - 5) % FRAME_BYTES;
    endcase
    // set-ddram instruction, bit 7 over the row base
    if (k == 0)
      return {1'b0, 1'b1, 7'h00};
    if (k == `LCD_COLS + 1)
      return {1'b0, 1'b1, `LCD_ROW2_BASE};
    if (k <= `LCD_COLS)
      return {1'b1, shadow[k-1]};
    return {1'b1, shadow[k-2]};
  endfunction

  // random write into the row that is not on the bus right now
  task automatic drive_host_write();
    lcd_pkg::lcd_pos_t pos;
    logic [7:0]        ch;
    wr_en <= 1'b0;
    if (row_known && ($urandom % 16 == 0))
    begin
      pos = {~cur_row, 4'($urandom % `LCD_COLS)};
      // printable ascii 0x20..0x7e
      ch  = 8'h20 + 8'($urandom % 95);
      wr_en   <= 1'b1;
      wr_pos  <= pos;
      wr_char <= ch;
      shadow[pos] = ch;
      writes++;
    end
  endtask

  // --------------------
  // stimulus and end of run
  // --------------------
  initial
  begin
    void'($urandom(32));
    rst_n   = 1'b0;
    wr_en   = 1'b0;
    wr_pos  = '0;
    wr_char = 8'h00;
    for (int i = 0; i < 2*`LCD_COLS; i++)
    begin
      shadow[i] = 8'h20;
    end
    repeat (16) @(posedge lcd_clk);
    rst_n <= 1'b1;
    while (byte_cnt < TOTAL_BYTES)
    begin
      @(posedge lcd_clk);
      drive_host_write();
    end
    wr_en <= 1'b0;
    @(posedge lcd_clk);
    $display("errors: %0d of %0d checks, %0d bytes, %0d host writes",
             errors, checks, byte_cnt, writes);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  // --------------------
  // bus monitor
  // --------------------
  // samples pins at each rising clock, e edges seen between samples
  initial
  begin
    cur_row    = 1'b0;
    row_known  = 1'b0;
    last_bus   = 9'h000;
    prev_e     = 1'b0;
    seen_rise  = 1'b0;
    long_gap   = 1'b0;
    stable_cnt = 0;
    e_hi_cnt   = 0;
    e_lo_cnt   = 0;
    byte_cnt   = 0;
    errors     = 0;
    checks     = 0;
    writes     = 0;
    cycle_cnt  = 0;
  end

  always @(posedge lcd_clk)
  begin
    if (rst_n)
    begin
      bus         = {lcd_rs, lcd_data};
      bus_changed = (bus != last_bus);
      stable_cnt  = bus_changed ? 0 : stable_cnt + 1;
      last_bus    = bus;
      check_value("lcd_rw low", lcd_rw, 1'b0);
      if (lcd_e && !prev_e)
      begin
        // e rising, check the low time just ended
        if (!seen_rise)
        begin
          check_value($sformatf("power-up wait of %0d cycles", e_lo_cnt),
                      e_lo_cnt >= `LCD_POWERUP_CYCLES, 1'b1);
          seen_rise = 1'b1;
        end
        else if (long_gap)
          check_value($sformatf("clear gap of %0d cycles", e_lo_cnt),
                      e_lo_cnt >= `LCD_CLEAR_CYCLES, 1'b1);
        else
          check_value($sformatf("byte gap of %0d cycles", e_lo_cnt),
                      e_lo_cnt >= `LCD_GAP_CYCLES, 1'b1);
        check_value("data and rs setup before e", stable_cnt >= `LCD_SETUP_CYCLES, 1'b1);
        e_hi_cnt = 1;
      end
      else if (lcd_e)
      begin
        e_hi_cnt++;
        check_value("data and rs stable under e", bus_changed, 1'b0);
      end
      else if (prev_e)
      begin
        // e falling, panel latches here
        check_value("e high width", e_hi_cnt, `LCD_E_HIGH_CYCLES);
        word.raw = lcd_data;
        long_gap = !lcd_rs && (word.raw >= 8'h01) && (word.raw <= 8'h03);
        // row-start decoded through the address view
        if (!lcd_rs && word.ddram.set_ddram)
        begin
          cur_row   <= (word.ddram.addr == `LCD_ROW2_BASE);
          row_known <= 1'b1;
        end
        if (byte_cnt < TOTAL_BYTES)
          check_value($sformatf("byte %0d rs and data", byte_cnt), bus, predict_byte(byte_cnt));
        byte_cnt++;
        e_lo_cnt = 1;
      end
      else
        e_lo_cnt++;
      prev_e = lcd_e;
    end
  end

  // watchdog
  always @(posedge lcd_clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: display stream stalled after %0d of %0d bytes", byte_cnt, TOTAL_BYTES);
      $display("TB FAILED");
      $finish;
    end
  end

endmodule
